// File: bench/ni_vc_link_tb.sv
// NI VC link testbench with table-driven send and receive checks against a cycle model

`timescale 1ns/10ps

`include "ni_config.svh"

module ni_vc_link_tb;

  import ni_pkg::*;

  localparam int unsigned NumPkt   = 6;
  localparam int unsigned MaxFlits = 32;

  typedef struct packed {
    logic [7:0]  len;
    logic [31:0] seed;
  } pkt_row_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  flit_t       dma_tx_flit_i;
  logic        dma_tx_valid_i;
  logic        dma_tx_ready_o;
  flit_t       link_tx_flit_o;
  logic        link_tx_valid_o;
  logic        link_tx_ready_i;
  vc_id_t      link_vc_o;
  flit_t       link_rx_flit_i;
  logic        link_rx_valid_i;
  logic        link_rx_ready_o;
  flit_t       dma_rx_flit_o;
  logic        dma_rx_valid_o;
  logic        dma_rx_ready_i;

  pkt_row_t    pkt_table [NumPkt];
  flit_t       exp_flit [`NI_NUM_VC][MaxFlits];
  int unsigned exp_wr [`NI_NUM_VC];
  int unsigned exp_rd [`NI_NUM_VC];
  int unsigned pushed [`NI_NUM_VC];
  logic        stalled [`NI_NUM_VC];
  vc_id_t      cur_lane;
  logic        send_active = 1'b0;
  int unsigned cycle_cnt   = 0;
  int unsigned cycle_limit = 1000;
  int unsigned rand_state  = 98334;
  int unsigned errors      = 0;
  int unsigned tests_bad   = 0;

  ni_vc_link ni_vc_link_i (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .dma_tx_flit_i   ( dma_tx_flit_i   ),
    .dma_tx_valid_i  ( dma_tx_valid_i  ),
    .dma_tx_ready_o  ( dma_tx_ready_o  ),
    .link_tx_flit_o  ( link_tx_flit_o  ),
    .link_tx_valid_o ( link_tx_valid_o ),
    .link_tx_ready_i ( link_tx_ready_i ),
    .link_vc_o       ( link_vc_o       ),
    .link_rx_flit_i  ( link_rx_flit_i  ),
    .link_rx_valid_i ( link_rx_valid_i ),
    .link_rx_ready_o ( link_rx_ready_o ),
    .dma_rx_flit_o   ( dma_rx_flit_o   ),
    .dma_rx_valid_o  ( dma_rx_valid_o  ),
    .dma_rx_ready_i  ( dma_rx_ready_i  )
  );

  always #5 clk_i = ~clk_i;

  // Cycles since reset release double as the plane model
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && (cycle_cnt >= cycle_limit)) begin
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic int unsigned lcg(input int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic vc_id_t plane_now();
    return vc_id_t'(cycle_cnt % `NI_NUM_VC);
  endfunction

  // HEAD first and TAIL last with payload from the packet seed
  function automatic flit_t make_flit(input int unsigned k, input int unsigned i);
    flit_t       f;
    int unsigned s_hi;
    int unsigned s_lo;
    s_hi = lcg(pkt_table[k].seed + i);
    s_lo = lcg(s_hi);
    if (i == 0) begin
      f.kind = HEAD;
    end else if (i == pkt_table[k].len - 1) begin
      f.kind = TAIL;
    end else begin
      f.kind = BODY;
    end
    f.payload = {s_hi[29:0], s_lo};
    return f;
  endfunction

  function automatic logic send_drained();
    for (int v = 0; v < `NI_NUM_VC; v++) begin
      if (exp_rd[v] != exp_wr[v]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic check_flit(input string name, input flit_t act, input flit_t exp);
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_vc(input string name, input vc_id_t act, input vc_id_t exp);
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, name, act, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, name, act, exp);
    end
  endtask

  task automatic report_test(input string name, input int unsigned mark);
    if (errors == mark) begin
      $display("%s: done, no errors", name);
    end else begin
      tests_bad++;
      $display("%s: done, %0d errors", name, errors - mark);
    end
  endtask

  // ----------------------------------------------------------------------
  // Send side
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (send_active) begin
      rand_state = lcg(rand_state);
      link_tx_ready_i <= (rand_state[31:30] != 2'b00);
    end else begin
      link_tx_ready_i <= 1'b0;
    end
  end

  // Link flits must match the front of their VC's expected queue
  always @(negedge clk_i) begin : send_monitor
    vc_id_t p;
    if (send_active) begin
      p = plane_now();
      // Lane fill is the pushes so far minus the flits taken by the link
      if (dma_tx_valid_i) begin
        check_bit("dma_tx_ready_o", dma_tx_ready_o,
                  (pushed[cur_lane] - exp_rd[cur_lane]) < `NI_LANE_DEPTH);
        if (dma_tx_ready_o) begin
          pushed[cur_lane]++;
        end
      end
      if (stalled[p]) begin
        check_bit("link_tx_valid_o", link_tx_valid_o, 1'b1);
      end
      if (link_tx_valid_o) begin
        check_vc("link_vc_o", link_vc_o, p);
        if (exp_rd[p] == exp_wr[p]) begin
          errors++;
          $display("at %0t a flit appeared on VC %0d with none left to send", $time, p);
        end else begin
          check_flit("link_tx_flit_o", link_tx_flit_o, exp_flit[p][exp_rd[p]]);
          stalled[p] = !link_tx_ready_i;
          if (link_tx_ready_i) begin
            exp_rd[p]++;
          end
        end
      end
    end
  end

  // Called on a rising edge and returns on the edge of the handshake
  task automatic send_flit(input flit_t f);
    logic took;
    dma_tx_flit_i  <= f;
    dma_tx_valid_i <= 1'b1;
    do begin
      @(negedge clk_i);
      took = dma_tx_ready_o;
      @(posedge clk_i);
    end while (!took);
  endtask

  // ----------------------------------------------------------------------
  // Receive side
  // ----------------------------------------------------------------------
  task automatic offer_refused(input flit_t f);
    link_rx_flit_i  <= f;
    link_rx_valid_i <= 1'b1;
    dma_rx_ready_i  <= 1'b1;
    for (int c = 0; c < `NI_NUM_VC + 1; c++) begin
      @(negedge clk_i);
      check_bit("dma_rx_valid_o", dma_rx_valid_o, 1'b0);
      check_bit("link_rx_ready_o", link_rx_ready_o, 1'b0);
      @(posedge clk_i);
    end
    link_rx_valid_i <= 1'b0;
  endtask

  // Head is offered only in a cycle owned by the target plane
  task automatic recv_head(input flit_t f, input vc_id_t target, output vc_id_t claim);
    @(negedge clk_i);
    while (vc_id_t'((cycle_cnt + 1) % `NI_NUM_VC) != target) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    link_rx_flit_i  <= f;
    link_rx_valid_i <= 1'b1;
    dma_rx_ready_i  <= 1'b1;
    @(negedge clk_i);
    check_vc("link_vc_o", link_vc_o, target);
    check_bit("dma_rx_valid_o", dma_rx_valid_o, 1'b1);
    check_bit("link_rx_ready_o", link_rx_ready_o, 1'b1);
    check_flit("dma_rx_flit_o", dma_rx_flit_o, f);
    claim = plane_now();
    @(posedge clk_i);
  endtask

  task automatic recv_flit(input flit_t f, input vc_id_t claim);
    logic took;
    logic pass;
    took = 1'b0;
    while (!took) begin
      rand_state = lcg(rand_state);
      link_rx_flit_i  <= f;
      link_rx_valid_i <= 1'b1;
      dma_rx_ready_i  <= (rand_state[31:30] != 2'b00);
      @(negedge clk_i);
      pass = (plane_now() == claim);
      check_bit("dma_rx_valid_o", dma_rx_valid_o, pass);
      check_bit("link_rx_ready_o", link_rx_ready_o, pass & dma_rx_ready_i);
      if (pass) begin
        check_flit("dma_rx_flit_o", dma_rx_flit_o, f);
      end
      took = pass & dma_rx_ready_i;
      @(posedge clk_i);
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin : main
    vc_id_t      claim;
    flit_t       f;
    int unsigned mark;
    int unsigned total;
    pkt_table[0] = '{len: 8'd3, seed: 32'h0000_1a2b};
    pkt_table[1] = '{len: 8'd2, seed: 32'h0003_c4d5};
    pkt_table[2] = '{len: 8'd4, seed: 32'h0000_77e1};
    pkt_table[3] = '{len: 8'd2, seed: 32'h0012_9f08};
    pkt_table[4] = '{len: 8'd5, seed: 32'h0000_5c3a};
    pkt_table[5] = '{len: 8'd3, seed: 32'h0b0e_6614};
    total = 0;
    for (int k = 0; k < NumPkt; k++) begin
      total += pkt_table[k].len;
    end
    cycle_limit = total * `NI_NUM_VC * 4 + 100;
    rst_ni          = 1'b0;
    dma_tx_flit_i   = '0;
    dma_tx_valid_i  = 1'b0;
    link_tx_ready_i = 1'b0;
    link_rx_flit_i  = '0;
    link_rx_valid_i = 1'b0;
    dma_rx_ready_i  = 1'b0;
    cur_lane        = '0;
    for (int v = 0; v < `NI_NUM_VC; v++) begin
      exp_wr[v]  = 0;
      exp_rd[v]  = 0;
      pushed[v]  = 0;
      stalled[v] = 1'b0;
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    mark = errors;
    @(negedge clk_i);
    check_bit("link_tx_valid_o", link_tx_valid_o, 1'b0);
    check_bit("dma_rx_valid_o", dma_rx_valid_o, 1'b0);
    check_vc("link_vc_o", link_vc_o, '0);
    report_test("reset state", mark);

    mark = errors;
    repeat (4 * `NI_NUM_VC) begin
      @(negedge clk_i);
      check_vc("link_vc_o", link_vc_o, plane_now());
    end
    report_test("plane rotation", mark);
    @(posedge clk_i);

    // Packet k goes to VC k mod NUM_VC in table order within a VC
    mark = errors;
    for (int k = 0; k < NumPkt; k++) begin
      for (int i = 0; i < pkt_table[k].len; i++) begin
        exp_flit[k % `NI_NUM_VC][exp_wr[k % `NI_NUM_VC]] = make_flit(k, i);
        exp_wr[k % `NI_NUM_VC]++;
      end
    end
    send_active <= 1'b1;
    for (int k = 0; k < NumPkt; k++) begin
      cur_lane = vc_id_t'(k % `NI_NUM_VC);
      for (int i = 0; i < pkt_table[k].len; i++) begin
        send_flit(make_flit(k, i));
      end
    end
    dma_tx_valid_i <= 1'b0;
    while (!send_drained()) begin
      @(posedge clk_i);
    end
    repeat (2 * `NI_NUM_VC) @(posedge clk_i);
    send_active <= 1'b0;
    report_test("send packets with link stalls", mark);

    mark = errors;
    for (int k = 0; k < NumPkt; k++) begin
      f      = make_flit(k, 0);
      f.kind = (k % 2) ? TAIL : BODY;
      offer_refused(f);
      recv_head(make_flit(k, 0), vc_id_t'(k % `NI_NUM_VC), claim);
      for (int i = 1; i < pkt_table[k].len; i++) begin
        recv_flit(make_flit(k, i), claim);
      end
    end
    link_rx_valid_i <= 1'b0;
    report_test("receive capture and release", mark);

    $display("4 tests run, %0d with errors, %0d errors in total", tests_bad, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+src
src/ni_pkg.sv
src/vc_plane_sched.sv
src/tx_vc_dispatch.sv
src/vc_lane_fifo.sv
src/tx_plane_mux.sv
src/rx_vc_capture.sv
src/ni_vc_link.sv
bench/ni_vc_link_tb.sv

// File: src/ni_config.svh
// NI VC link configuration: flit geometry, VC plane count and send lane depth

`ifndef NI_CONFIG_SVH
`define NI_CONFIG_SVH

// ----------------------------------------------------------------------
// Flit format
// ----------------------------------------------------------------------
// Full flit width on the DMA stream and the router link
`define NI_FLIT_W 64

// Kind field occupies the two bits from here up to the MSB
`define NI_KIND_LSB 62

// ----------------------------------------------------------------------
// Virtual channels
// ----------------------------------------------------------------------
`define NI_NUM_VC 2

// Flits buffered per VC on the send side
`define NI_LANE_DEPTH 4

`endif

// File: src/ni_pkg.sv
// NI VC link types: flit layout, flit kinds and VC index with its wrap helper

`include "ni_config.svh"

package ni_pkg;

  // ----------------------------------------------------------------------
  // Flit kind, taken from the top two bits of every flit
  // ----------------------------------------------------------------------
  // 2'b10 is not used by the router
  typedef enum logic [1:0] {
    BODY = 2'b00,
    HEAD = 2'b01,
    TAIL = 2'b11
  } flit_kind_e;

  // Kind in the MSBs, payload below it
  typedef struct packed {
    flit_kind_e                 kind;
    logic [`NI_KIND_LSB-1:0]    payload;
  } flit_t;

  // ----------------------------------------------------------------------
  // VC plane index
  // ----------------------------------------------------------------------
  typedef logic [$clog2(`NI_NUM_VC)-1:0] vc_id_t;

  // Next VC in round-robin order
  function automatic vc_id_t next_vc(input vc_id_t vc);
    if (vc == vc_id_t'(`NI_NUM_VC - 1)) begin
      return '0;
    end
    return vc_id_t'(vc + 1'b1);
  endfunction

endpackage

// File: src/ni_vc_link.sv
// NI VC link top level joining the DMA stream to the router link over rotating VC planes

`timescale 1ns/10ps

`include "ni_config.svh"

module ni_vc_link (
  input  logic           clk_i,
  input  logic           rst_ni,
  // DMA send stream
  input  ni_pkg::flit_t  dma_tx_flit_i,
  input  logic           dma_tx_valid_i,
  output logic           dma_tx_ready_o,
  // Router link, send side
  output ni_pkg::flit_t  link_tx_flit_o,
  output logic           link_tx_valid_o,
  input  logic           link_tx_ready_i,
  output ni_pkg::vc_id_t link_vc_o,
  // Router link, receive side
  input  ni_pkg::flit_t  link_rx_flit_i,
  input  logic           link_rx_valid_i,
  output logic           link_rx_ready_o,
  // DMA receive stream
  output ni_pkg::flit_t  dma_rx_flit_o,
  output logic           dma_rx_valid_o,
  input  logic           dma_rx_ready_i
);

  import ni_pkg::*;

  vc_id_t                       plane;
  flit_t                        lane_in_flit;
  logic    [`NI_NUM_VC-1:0]     lane_push;
  logic    [`NI_NUM_VC-1:0]     lane_not_full;
  logic    [`NI_NUM_VC-1:0]     lane_not_empty;
  logic    [`NI_NUM_VC-1:0]     lane_pop;
  flit_t   [`NI_NUM_VC-1:0]     lane_head;

  // ----------------------------------------------------------------------
  // Plane schedule
  // ----------------------------------------------------------------------
  vc_plane_sched vc_plane_sched_i (
    .clk_i   ( clk_i  ),
    .rst_ni  ( rst_ni ),
    .plane_o ( plane  )
  );

  assign link_vc_o = plane;

  // ----------------------------------------------------------------------
  // Send path
  // ----------------------------------------------------------------------
  tx_vc_dispatch tx_vc_dispatch_i (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .flit_i       ( dma_tx_flit_i  ),
    .valid_i      ( dma_tx_valid_i ),
    .ready_o      ( dma_tx_ready_o ),
    .lane_push_o  ( lane_push      ),
    .lane_flit_o  ( lane_in_flit   ),
    .lane_ready_i ( lane_not_full  )
  );

  // One queue per VC
  for (genvar i = 0; i < `NI_NUM_VC; i++) begin : gen_lane
    vc_lane_fifo #(
      .DEPTH ( `NI_LANE_DEPTH )
    ) vc_lane_fifo_i (
      .clk_i       ( clk_i             ),
      .rst_ni      ( rst_ni            ),
      .push_i      ( lane_push[i]      ),
      .flit_i      ( lane_in_flit      ),
      .not_full_o  ( lane_not_full[i]  ),
      .pop_i       ( lane_pop[i]       ),
      .flit_o      ( lane_head[i]      ),
      .not_empty_o ( lane_not_empty[i] )
    );
  end

  tx_plane_mux tx_plane_mux_i (
    .plane_i      ( plane           ),
    .lane_flit_i  ( lane_head       ),
    .lane_valid_i ( lane_not_empty  ),
    .lane_pop_o   ( lane_pop        ),
    .flit_o       ( link_tx_flit_o  ),
    .valid_o      ( link_tx_valid_o ),
    .ready_i      ( link_tx_ready_i )
  );

  // ----------------------------------------------------------------------
  // Receive path
  // ----------------------------------------------------------------------
  // Data goes straight through and only the handshake is gated
  assign dma_rx_flit_o = link_rx_flit_i;

  rx_vc_capture rx_vc_capture_i (
    .clk_i   ( clk_i           ),
    .rst_ni  ( rst_ni          ),
    .plane_i ( plane           ),
    .flit_i  ( link_rx_flit_i  ),
    .valid_i ( link_rx_valid_i ),
    .ready_o ( link_rx_ready_o ),
    .valid_o ( dma_rx_valid_o  ),
    .ready_i ( dma_rx_ready_i  )
  );

endmodule

// File: src/rx_vc_capture.sv
// Receive VC capture that locks onto the VC of an incoming head until its tail

`timescale 1ns/10ps

module rx_vc_capture (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ni_pkg::vc_id_t plane_i,
  // Router link, receive side
  input  ni_pkg::flit_t  flit_i,
  input  logic           valid_i,
  output logic           ready_o,
  // DMA receive stream
  output logic           valid_o,
  input  logic           ready_i
);

  import ni_pkg::*;

  logic   busy_q;
  vc_id_t claim_q;
  logic   pass;
  logic   accept;

  // ----------------------------------------------------------------------
  // Gating
  // ----------------------------------------------------------------------
  // Idle takes heads only and busy takes the claimed plane only
  always_comb begin
    if (busy_q) begin
      pass = (plane_i == claim_q);
    end else begin
      pass = (flit_i.kind == HEAD);
    end
  end

  assign valid_o = valid_i & pass;
  assign ready_o = ready_i & pass;
  assign accept  = valid_i & ready_o;

  // ----------------------------------------------------------------------
  // Claim state
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      claim_q <= '0;
    end else if (accept) begin
      if (!busy_q) begin
        // This plane now owns the receive path
        busy_q  <= 1'b1;
        claim_q <= plane_i;
      end else if (flit_i.kind == TAIL) begin
        busy_q <= 1'b0;
      end
    end
  end

  // A new head on the claimed plane means the router lost a tail
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (busy_q && valid_i && (plane_i == claim_q)) |-> (flit_i.kind != HEAD))
    else $error("Receive head arrived inside a claimed packet");

endmodule

// File: src/tx_plane_mux.sv
// Send plane mux: puts the active plane's lane head on the link

`timescale 1ns/10ps

`include "ni_config.svh"

module tx_plane_mux (
  input  ni_pkg::vc_id_t                         plane_i,
  // Lane heads
  input  ni_pkg::flit_t   [`NI_NUM_VC-1:0]       lane_flit_i,
  input  logic            [`NI_NUM_VC-1:0]       lane_valid_i,
  output logic            [`NI_NUM_VC-1:0]       lane_pop_o,
  // Router link, send side
  output ni_pkg::flit_t                          flit_o,
  output logic                                   valid_o,
  input  logic                                   ready_i
);

  import ni_pkg::*;

  // ----------------------------------------------------------------------
  // Plane select
  // ----------------------------------------------------------------------
  // Other lanes keep their head until their slot comes round
  assign flit_o  = lane_flit_i[plane_i];
  assign valid_o = lane_valid_i[plane_i];

  // Pop only the owning lane, and only on a link handshake
  always_comb begin
    for (int unsigned i = 0; i < `NI_NUM_VC; i++) begin
      lane_pop_o[i] = (plane_i == vc_id_t'(i)) & lane_valid_i[i] & ready_i;
    end
  end

endmodule

// File: src/tx_vc_dispatch.sv
// Send dispatcher: gives each outgoing packet the next VC lane, round-robin

`timescale 1ns/10ps

`include "ni_config.svh"

module tx_vc_dispatch (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // DMA send stream
  input  ni_pkg::flit_t         flit_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  // Lane write side
  output logic [`NI_NUM_VC-1:0] lane_push_o,
  output ni_pkg::flit_t         lane_flit_o,
  input  logic [`NI_NUM_VC-1:0] lane_ready_i
);

  import ni_pkg::*;

  vc_id_t lane_q;
  logic   accept;

  // ----------------------------------------------------------------------
  // Steering
  // ----------------------------------------------------------------------
  // Only the lane owning the current packet sees the flit
  assign ready_o     = lane_ready_i[lane_q];
  assign accept      = valid_i & ready_o;
  assign lane_flit_o = flit_i;

  always_comb begin
    lane_push_o         = '0;
    lane_push_o[lane_q] = accept;
  end

  // ----------------------------------------------------------------------
  // Lane selection
  // ----------------------------------------------------------------------
  // Whole packets stay on one VC, so move on only after the tail
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_q <= '0;
    end else if (accept && (flit_i.kind == TAIL)) begin
      lane_q <= next_vc(lane_q);
    end
  end

  // DMA must hold a stalled flit until the lane takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && !ready_o) |=> (valid_i && ($stable(flit_i))))
    else $error("DMA send flit changed while stalled");

endmodule

// File: src/vc_lane_fifo.sv
// Send lane FIFO: circular flit buffer for one VC

`timescale 1ns/10ps

`include "ni_config.svh"

module vc_lane_fifo #(
  parameter int unsigned DEPTH = `NI_LANE_DEPTH
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  // Write side
  input  logic          push_i,
  input  ni_pkg::flit_t flit_i,
  output logic          not_full_o,
  // Read side
  input  logic          pop_i,
  output ni_pkg::flit_t flit_o,
  output logic          not_empty_o
);

  import ni_pkg::*;

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  flit_t           mem_q [DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  // Pointer advance with wrap at DEPTH
  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(DEPTH - 1)) begin
      return '0;
    end
    return PtrW'(ptr + 1'b1);
  endfunction

  assign not_full_o  = (count_q != CntW'(DEPTH));
  assign not_empty_o = (count_q != '0);
  assign do_push     = push_i & not_full_o;
  assign do_pop      = pop_i & not_empty_o;

  // Head is read straight from storage
  assign flit_o = mem_q[rd_ptr_q];

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> not_full_o)
    else $error("Push into full send lane");

  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> not_empty_o)
    else $error("Pop from empty send lane");

endmodule

// File: src/vc_plane_sched.sv
// VC plane scheduler: rotates link ownership over the VC planes, one per cycle

`timescale 1ns/10ps

module vc_plane_sched (
  input  logic           clk_i,
  input  logic           rst_ni,
  output ni_pkg::vc_id_t plane_o
);

  import ni_pkg::*;

  vc_id_t plane_q;

  // Time slot owner, shared by send and receive
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      plane_q <= '0;
    end else begin
      plane_q <= next_vc(plane_q);
    end
  end

  assign plane_o = plane_q;

endmodule
